//--- source/noc_ni_pkg.sv
`default_nettype none

package noc_ni_pkg;

   ////////////////////////////////////////////////////////////
   // ring link encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      flit_idle = 2'b00,   // nothing on the link
      flit_head = 2'b01,
      flit_body = 2'b10,
      flit_tail = 2'b11
   } flit_type_t;

   // receive fifo selected by the sender at the next node
   typedef enum logic [1:0]
   {
      dest_pass_req  = 2'b00,
      dest_pass_rep  = 2'b01,
      dest_local_req = 2'b10,
      dest_local_rep = 2'b11
   } dest_fifo_t;

   typedef struct packed
   {
      logic [3:0] dest_node;   // target node on the ring
      logic [1:0] spare;
      logic [4:0] cmd;         // command, bits 9:5 of the flit
      logic [4:0] misc;
   } head_flit_t;

   // head flits decode by field, body flits just carry data
   typedef union packed
   {
      head_flit_t  head;
      logic [15:0] body;
   } flit_u;

   typedef struct packed
   {
      flit_type_t ctrl;   // bits 17:16
      flit_u      flit;
   } ni_entry_t;

   ////////////////////////////////////////////////////////////
   // reply commands
   ////////////////////////////////////////////////////////////

   typedef logic [4:0] cmd_t;

   localparam cmd_t wbrep         = 5'b10000;
   localparam cmd_t c2hinvrep     = 5'b10001;
   localparam cmd_t flushrep      = 5'b10010;
   localparam cmd_t atflurep      = 5'b10011;
   localparam cmd_t shrep         = 5'b11000;
   localparam cmd_t exrep         = 5'b11001;
   localparam cmd_t sh_exrep      = 5'b11010;
   localparam cmd_t scflurep      = 5'b11100;
   localparam cmd_t instrep       = 5'b10100;
   localparam cmd_t c2cinvrep     = 5'b11011;
   localparam cmd_t nackrep       = 5'b10101;
   localparam cmd_t flushfail_rep = 5'b10110;
   localparam cmd_t wbfail_rep    = 5'b10111;

   // whole reply length in flits, head included
   function automatic logic [3:0] rep_msg_flits(input cmd_t cmd);
      case (cmd)
         atflurep, wbrep:
            return 4'd11;   // head plus a full cache line
         exrep, shrep, instrep, sh_exrep:
            return 4'd9;
         nackrep, flushrep, c2hinvrep, flushfail_rep, wbfail_rep:
            return 4'd3;
         default:
            return 4'd1;    // head only
      endcase
   endfunction

endpackage

`default_nettype wire

//--- source/flit_fifo.sv
`default_nettype none

module flit_fifo
   import noc_ni_pkg::*;
#(
   parameter int fifo_depth = 16
)
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         wr_en,
   input  wire ni_entry_t              wr_data,
   input  wire                         rd_en,
   output ni_entry_t                   rd_data,
   output logic                        empty,
   output logic                        full,
   output logic [$clog2(fifo_depth):0] used_slots
);

   localparam int ptr_w = $clog2(fifo_depth);

   ni_entry_t          mem [fifo_depth];
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic [ptr_w:0]     count;   // one extra bit so full is visible

   // pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + wr_en - rd_en;   // both strobes cancel out
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   assign rd_data    = mem[rd_ptr];   // show-ahead head entry
   assign empty      = (count == '0);
   assign full       = (count == (ptr_w + 1)'(fifo_depth));
   assign used_slots = count;

   ////////////////////////////////////////////////////////////
   // handshake checks
   ////////////////////////////////////////////////////////////

   a_no_overflow : assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !full);

   a_no_underflow : assert property (@(posedge clk) disable iff (reset)
      rd_en |-> !empty);

endmodule

`default_nettype wire

//--- source/ring_receive.sv
`default_nettype none

module ring_receive
   import noc_ni_pkg::*;
#(
   parameter int fifo_depth = 16
)
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire flit_type_t             ctrl_in,
   input  wire flit_u                  flit_in,
   input  wire dest_fifo_t             dest_fifo_in,
   input  wire                         en_in_req_deq,
   input  wire                         en_in_rep_deq,
   input  wire                         pass_req_pop,
   input  wire                         pass_rep_pop,
   output ni_entry_t                   pass_req_head,
   output ni_entry_t                   pass_rep_head,
   output logic                        pass_req_empty,
   output logic                        pass_rep_empty,
   output ni_entry_t                   deq_req_data,
   output ni_entry_t                   deq_rep_data,
   output logic                        req_rdy,
   output logic                        rep_rdy,
   output logic                        en_pass_req,
   output logic                        en_pass_rep,
   output logic                        en_local_req,
   output logic                        en_local_rep,
   output logic [$clog2(fifo_depth):0] used_slots_pass_rep
);

   ni_entry_t                   in_entry;
   ni_entry_t                   head_q [4];   // indexed by dest_fifo_t
   logic [3:0]                  wr_en;
   logic [3:0]                  rd_en;
   logic [3:0]                  empty_q;
   logic [3:0]                  full_q;
   logic [$clog2(fifo_depth):0] used_q [4];

   assign in_entry.ctrl = ctrl_in;
   assign in_entry.flit = flit_in;

   // pops in dest_fifo_t order
   assign rd_en = {en_in_rep_deq, en_in_req_deq, pass_rep_pop, pass_req_pop};

   for (genvar i = 0; i < 4; i++)
   begin : g_rx
      // write demux, one fifo per incoming flit
      assign wr_en[i] = (ctrl_in != flit_idle) && (dest_fifo_in == dest_fifo_t'(i));

      flit_fifo #(.fifo_depth(fifo_depth)) u_fifo
      (
         .clk        (clk),
         .reset      (reset),
         .wr_en      (wr_en[i]),
         .wr_data    (in_entry),
         .rd_en      (rd_en[i]),
         .rd_data    (head_q[i]),
         .empty      (empty_q[i]),
         .full       (full_q[i]),
         .used_slots (used_q[i])
      );
   end

   assign pass_req_head  = head_q[dest_pass_req];
   assign pass_rep_head  = head_q[dest_pass_rep];
   assign pass_req_empty = empty_q[dest_pass_req];
   assign pass_rep_empty = empty_q[dest_pass_rep];
   assign deq_req_data   = head_q[dest_local_req];   // to local agents
   assign deq_rep_data   = head_q[dest_local_rep];
   assign req_rdy        = !empty_q[dest_local_req];
   assign rep_rdy        = !empty_q[dest_local_rep];

   // not-full levels back to the previous node
   assign en_pass_req  = !full_q[dest_pass_req];
   assign en_pass_rep  = !full_q[dest_pass_rep];
   assign en_local_req = !full_q[dest_local_req];
   assign en_local_rep = !full_q[dest_local_rep];

   assign used_slots_pass_rep = used_q[dest_pass_rep];   // reply credit for previous node

   // previous node must honour the enable it saw
   a_sender_obeys_enable : assert property (@(posedge clk) disable iff (reset)
      (ctrl_in != flit_idle) |-> !full_q[dest_fifo_in]);

endmodule

`default_nettype wire

//--- source/ring_transmit_arbiter.sv
`default_nettype none

module ring_transmit_arbiter
   import noc_ni_pkg::*;
#(
   parameter int         fifo_depth = 16,
   parameter logic [3:0] node_id    = 4'd3,
   parameter int         ring_nodes = 8
)
(
   input  wire                         clk,
   input  wire                         reset,
   input  wire ni_entry_t              pass_req_head,
   input  wire ni_entry_t              pass_rep_head,
   input  wire ni_entry_t              inj_req_head,
   input  wire ni_entry_t              inj_rep_head,
   input  wire                         pass_req_empty,
   input  wire                         pass_rep_empty,
   input  wire                         inj_req_empty,
   input  wire                         inj_rep_empty,
   input  wire                         en_local_req_in,
   input  wire                         en_local_rep_in,
   input  wire                         en_pass_req_in,
   input  wire                         en_pass_rep_in,
   input  wire [$clog2(fifo_depth):0]  used_slots_pass_rep_in,
   output logic                        pass_req_pop,
   output logic                        pass_rep_pop,
   output logic                        inj_req_pop,
   output logic                        inj_rep_pop,
   output flit_type_t                  ctrl_out,
   output flit_u                       flit_out,
   output dest_fifo_t                  dest_fifo_out
);

   localparam int         cnt_w     = $clog2(fifo_depth) + 1;
   localparam logic [3:0] next_node = 4'((node_id + 1) % ring_nodes);

   // source index is also the priority with 0 first
   localparam logic [1:0] src_pass_rep = 2'd0;
   localparam logic [1:0] src_inj_rep  = 2'd1;
   localparam logic [1:0] src_pass_req = 2'd2;
   localparam logic [1:0] src_inj_req  = 2'd3;

   typedef struct packed
   {
      logic       active;   // a message owns the link
      logic [1:0] src;
      dest_fifo_t dest;
   } lock_t;

   lock_t            lock_q;
   ni_entry_t        src_head [4];
   logic [3:0]       src_empty;
   logic [1:0]       sel_src;
   ni_entry_t        sel_head;
   logic             is_rep;
   logic             is_head;
   dest_fifo_t       dest;
   logic             dest_en;
   logic [3:0]       msg_len;
   logic [cnt_w-1:0] free_slots;
   logic             credit_ok;
   logic             pop;
   logic [3:0]       pop_vec;

   assign src_head[src_pass_rep] = pass_rep_head;
   assign src_head[src_inj_rep]  = inj_rep_head;
   assign src_head[src_pass_req] = pass_req_head;
   assign src_head[src_inj_req]  = inj_req_head;
   assign src_empty = {inj_req_empty, pass_req_empty, inj_rep_empty, pass_rep_empty};

   ////////////////////////////////////////////////////////////
   // source select and routing
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      sel_src = lock_q.src;   // locked message keeps its source
      if (!lock_q.active)
      begin
         if (!src_empty[src_pass_rep])
            sel_src = src_pass_rep;
         else if (!src_empty[src_inj_rep])
            sel_src = src_inj_rep;
         else if (!src_empty[src_pass_req])
            sel_src = src_pass_req;
         else
            sel_src = src_inj_req;
      end
   end

   assign sel_head = src_head[sel_src];
   assign is_rep   = !sel_src[1];
   assign is_head  = (sel_head.ctrl == flit_head);
   assign msg_len  = rep_msg_flits(sel_head.flit.head.cmd);

   always_comb
   begin
      if (lock_q.active)
         dest = lock_q.dest;
      else if (sel_head.flit.head.dest_node == next_node)   // lands at the next node
         dest = is_rep ? dest_local_rep : dest_local_req;
      else
         dest = is_rep ? dest_pass_rep : dest_pass_req;
   end

   always_comb
   begin
      case (dest)
         dest_pass_req  : dest_en = en_pass_req_in;
         dest_pass_rep  : dest_en = en_pass_rep_in;
         dest_local_req : dest_en = en_local_req_in;
         default        : dest_en = en_local_rep_in;
      endcase
   end

   // local reply enters the pass ring only if the whole message fits there
   assign free_slots = cnt_w'(fifo_depth) - used_slots_pass_rep_in;
   assign credit_ok  = !(sel_src == src_inj_rep && is_head && dest == dest_pass_rep)
                       || (free_slots >= cnt_w'(msg_len));

   assign pop     = !src_empty[sel_src] && dest_en && credit_ok;
   assign pop_vec = pop ? (4'b0001 << sel_src) : 4'b0000;

   assign pass_rep_pop = pop_vec[src_pass_rep];
   assign inj_rep_pop  = pop_vec[src_inj_rep];
   assign pass_req_pop = pop_vec[src_pass_req];
   assign inj_req_pop  = pop_vec[src_inj_req];

   ////////////////////////////////////////////////////////////
   // message lock and output register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         lock_q <= '{active: 1'b0, src: src_pass_rep, dest: dest_pass_req};
      else if (pop)
      begin
         if (is_head && !(is_rep && msg_len == 4'd1))   // single flit reply never locks
            lock_q <= '{active: 1'b1, src: sel_src, dest: dest};
         else if (sel_head.ctrl == flit_tail)
            lock_q.active <= 1'b0;   // message done
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         ctrl_out <= flit_idle;
      else
         ctrl_out <= pop ? sel_head.ctrl : flit_idle;   // idle while waiting
   end

   always_ff @(posedge clk)
   begin
      flit_out      <= sel_head.flit;
      dest_fifo_out <= dest;
   end

   // a new head only starts once the locked message has ended
   a_head_unlocked : assert property (@(posedge clk) disable iff (reset)
      (pop && is_head) |-> !lock_q.active);

   // upstream fifos must deliver body and tail flits only inside a message
   a_framing : assert property (@(posedge clk) disable iff (reset)
      (pop && !is_head) |-> lock_q.active);

endmodule

`default_nettype wire

//--- source/network_interface.sv
`default_nettype none

module network_interface
   import noc_ni_pkg::*;
#(
   parameter int         fifo_depth = 16,
   parameter logic [3:0] node_id    = 4'd3,
   parameter int         ring_nodes = 8
)
(
   input  wire                         clk,
   input  wire                         reset,
   // previous node
   input  wire flit_type_t             ctrl_in,
   input  wire flit_u                  flit_in,
   input  wire dest_fifo_t             dest_fifo_in,
   output logic                        en_pass_req,
   output logic                        en_pass_rep,
   output logic                        en_local_req,
   output logic                        en_local_rep,
   output logic [$clog2(fifo_depth):0] used_slots_pass_rep,
   // local agents
   input  wire ni_entry_t              enq_req_data,
   input  wire ni_entry_t              enq_rep_data,
   input  wire                         en_out_req_enq,
   input  wire                         en_out_rep_enq,
   output logic                        out_req_rdy,
   output logic                        out_rep_rdy,
   output ni_entry_t                   deq_req_data,
   output ni_entry_t                   deq_rep_data,
   output logic                        req_rdy,
   output logic                        rep_rdy,
   input  wire                         en_in_req_deq,
   input  wire                         en_in_rep_deq,
   // next node
   input  wire                         en_local_req_in,
   input  wire                         en_local_rep_in,
   input  wire                         en_pass_req_in,
   input  wire                         en_pass_rep_in,
   input  wire [$clog2(fifo_depth):0]  used_slots_pass_rep_in,
   output flit_type_t                  ctrl_out,
   output flit_u                       flit_out,
   output dest_fifo_t                  dest_fifo_out
);

   ni_entry_t pass_req_head, pass_rep_head;   // pass fifo heads to the arbiter
   ni_entry_t inj_req_head, inj_rep_head;
   logic      pass_req_empty, pass_rep_empty;
   logic      inj_req_empty, inj_rep_empty;
   logic      inj_req_full, inj_rep_full;
   logic      pass_req_pop, pass_rep_pop;
   logic      inj_req_pop, inj_rep_pop;

   assign out_req_rdy = !inj_req_full;
   assign out_rep_rdy = !inj_rep_full;

   ring_receive #(.fifo_depth(fifo_depth)) u_receive
   (
      .clk                 (clk),
      .reset               (reset),
      .ctrl_in             (ctrl_in),
      .flit_in             (flit_in),
      .dest_fifo_in        (dest_fifo_in),
      .en_in_req_deq       (en_in_req_deq),
      .en_in_rep_deq       (en_in_rep_deq),
      .pass_req_pop        (pass_req_pop),
      .pass_rep_pop        (pass_rep_pop),
      .pass_req_head       (pass_req_head),
      .pass_rep_head       (pass_rep_head),
      .pass_req_empty      (pass_req_empty),
      .pass_rep_empty      (pass_rep_empty),
      .deq_req_data        (deq_req_data),
      .deq_rep_data        (deq_rep_data),
      .req_rdy             (req_rdy),
      .rep_rdy             (rep_rdy),
      .en_pass_req         (en_pass_req),
      .en_pass_rep         (en_pass_rep),
      .en_local_req        (en_local_req),
      .en_local_rep        (en_local_rep),
      .used_slots_pass_rep (used_slots_pass_rep)
   );

   ////////////////////////////////////////////////////////////
   // inject fifos, filled by local agents
   ////////////////////////////////////////////////////////////

   flit_fifo #(.fifo_depth(fifo_depth)) u_inj_req
   (
      .clk        (clk),
      .reset      (reset),
      .wr_en      (en_out_req_enq),
      .wr_data    (enq_req_data),
      .rd_en      (inj_req_pop),
      .rd_data    (inj_req_head),
      .empty      (inj_req_empty),
      .full       (inj_req_full),
      .used_slots ()
   );

   flit_fifo #(.fifo_depth(fifo_depth)) u_inj_rep
   (
      .clk        (clk),
      .reset      (reset),
      .wr_en      (en_out_rep_enq),
      .wr_data    (enq_rep_data),
      .rd_en      (inj_rep_pop),
      .rd_data    (inj_rep_head),
      .empty      (inj_rep_empty),
      .full       (inj_rep_full),
      .used_slots ()
   );

   ring_transmit_arbiter #(
      .fifo_depth (fifo_depth),
      .node_id    (node_id),
      .ring_nodes (ring_nodes)
   ) u_transmit
   (
      .clk                    (clk),
      .reset                  (reset),
      .pass_req_head          (pass_req_head),
      .pass_rep_head          (pass_rep_head),
      .inj_req_head           (inj_req_head),
      .inj_rep_head           (inj_rep_head),
      .pass_req_empty         (pass_req_empty),
      .pass_rep_empty         (pass_rep_empty),
      .inj_req_empty          (inj_req_empty),
      .inj_rep_empty          (inj_rep_empty),
      .en_local_req_in        (en_local_req_in),
      .en_local_rep_in        (en_local_rep_in),
      .en_pass_req_in         (en_pass_req_in),
      .en_pass_rep_in         (en_pass_rep_in),
      .used_slots_pass_rep_in (used_slots_pass_rep_in),
      .pass_req_pop           (pass_req_pop),
      .pass_rep_pop           (pass_rep_pop),
      .inj_req_pop            (inj_req_pop),
      .inj_rep_pop            (inj_rep_pop),
      .ctrl_out               (ctrl_out),
      .flit_out               (flit_out),
      .dest_fifo_out          (dest_fifo_out)
   );

endmodule

`default_nettype wire

//--- sim/network_interface_tb.sv
`default_nettype none

module network_interface_tb
   import noc_ni_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int         fifo_depth     = 16;
   localparam logic [3:0] node_id        = 4'd3;
   localparam int         ring_nodes     = 8;
   localparam int         cnt_w          = $clog2(fifo_depth) + 1;
   localparam logic [3:0] next_node      = 4'((node_id + 1) % ring_nodes);
   localparam int         msgs_per_gen   = 100;   // for each of ring in, inject req and inject rep
   localparam int         max_msg_flits  = 11;
   localparam int         timeout_cycles = 3 * msgs_per_gen * max_msg_flits + 700;
   localparam int         ref_depth      = 4096;
   // reference queues 0..3 follow dest_fifo_t and 4..5 are the inject paths
   localparam int         q_local_req    = 2;
   localparam int         q_local_rep    = 3;
   localparam int         q_inj_req      = 4;
   localparam int         q_inj_rep      = 5;

   logic             clk;
   logic             reset;
   flit_type_t       ctrl_in;
   flit_u            flit_in;
   dest_fifo_t       dest_fifo_in;
   logic             en_pass_req, en_pass_rep, en_local_req, en_local_rep;
   logic [cnt_w-1:0] used_slots_pass_rep;
   ni_entry_t        enq_req_data, enq_rep_data;
   logic             en_out_req_enq, en_out_rep_enq;
   logic             out_req_rdy, out_rep_rdy;
   ni_entry_t        deq_req_data, deq_rep_data;
   logic             req_rdy, rep_rdy;
   logic             en_in_req_deq, en_in_rep_deq;
   logic             en_local_req_in, en_local_rep_in, en_pass_req_in, en_pass_rep_in;
   logic [cnt_w-1:0] used_slots_pass_rep_in;
   flit_type_t       ctrl_out;
   flit_u            flit_out;
   dest_fifo_t       dest_fifo_out;

   integer           seed;
   ni_entry_t        ref_mem [6][ref_depth];   // expected flits per path
   int               wr_i [6];
   int               rd_i [6];
   int               g_q [3];      // generators for ring in (0), inject req (1) and inject rep (2)
   int               g_len [3];
   int               g_left [3];
   int               g_msgs [3];
   head_flit_t       g_head [3];
   logic             out_active;   // a message owns the ring output
   int               out_src;
   dest_fifo_t       out_dest;
   logic [3:0]       prev_en;      // next node enables of last cycle indexed by dest_fifo_t
   logic [cnt_w-1:0] prev_used;
   logic             deq_on;
   logic             credit_on;
   int               cycles;
   ni_entry_t        e;

   network_interface #(
      .fifo_depth (fifo_depth),
      .node_id    (node_id),
      .ring_nodes (ring_nodes)
   ) dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   ////////////////////////////////////////////////////////////
   // model helpers
   ////////////////////////////////////////////////////////////

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // reply length table including the head flit
   function automatic int expected_len(input cmd_t cmd);
      case (cmd)
         wbrep, atflurep: return 11;
         shrep, exrep, sh_exrep, instrep: return 9;
         c2hinvrep, flushrep, nackrep, flushfail_rep, wbfail_rep: return 3;
         default: return 1;
      endcase
   endfunction

   function automatic logic link_enable(input int qi);
      case (qi)
         0: return en_pass_req;
         1: return en_pass_rep;
         2: return en_local_req;
         default: return en_local_rep;
      endcase
   endfunction

   function automatic logic all_done();
      logic done;
      done = !out_active;
      for (int i = 0; i < 3; i++)
         if (g_left[i] != 0 || g_msgs[i] < msgs_per_gen)
            done = 1'b0;
      for (int i = 0; i < 6; i++)
         if (rd_i[i] != wr_i[i])
            done = 1'b0;   // flits still owed
      return done;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_entry(input string name, input ni_entry_t got, input ni_entry_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_dest(input string name, input dest_fifo_t got, input dest_fifo_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %s expected %s",
                            $time, name, got.name(), exp.name()));
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [cnt_w-1:0] got,
                              input logic [cnt_w-1:0] exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic push(input int qi, input ni_entry_t ent);
      ref_mem[qi][wr_i[qi]] = ent;
      wr_i[qi]++;
   endtask

   task automatic pop_expected(input int qi, output ni_entry_t ent);
      if (rd_i[qi] == wr_i[qi])
         fail_run($sformatf("flit at %0t from path %0d where none was sent", $time, qi));
      else
      begin
         ent = ref_mem[qi][rd_i[qi]];
         rd_i[qi]++;
      end
   endtask

   // new message header with the path index tagged into misc
   task automatic start_msg(input int g, input int qi);
      cmd_t       cmd;
      logic [3:0] node;
      g_q[g] = qi;
      node = (rand_below(3) == 0) ? next_node : 4'(rand_below(ring_nodes));
      if (qi % 2 == 1)
      begin
         cmd      = {1'b1, 4'(rand_below(16))};   // reply codes live in the upper half
         g_len[g] = expected_len(cmd);
      end
      else
      begin
         cmd      = {1'b0, 4'(rand_below(16))};
         g_len[g] = 2 + rand_below(3);            // 2 to 4 flits with tail last
      end
      g_head[g].dest_node = node;
      g_head[g].spare     = 2'(rand_below(4));
      g_head[g].cmd       = cmd;
      g_head[g].misc      = {3'(qi), 2'(g_msgs[g])};
      g_left[g] = g_len[g];
      g_msgs[g]++;
   endtask

   task automatic send_flit(input int g, output ni_entry_t ent);
      if (g_left[g] == g_len[g])
      begin
         ent.ctrl      = flit_head;
         ent.flit.head = g_head[g];
      end
      else
      begin
         ent.ctrl      = (g_left[g] == 1) ? flit_tail : flit_body;
         ent.flit.body = 16'(rand_below(65536));
      end
      push(g_q[g], ent);
      g_left[g]--;
   endtask

   ////////////////////////////////////////////////////////////
   // per cycle checks and drive
   ////////////////////////////////////////////////////////////

   task automatic check_ring_output();
      ni_entry_t  got;
      ni_entry_t  exp;
      dest_fifo_t want;
      int         qi;
      logic       rep;
      if (ctrl_out == flit_idle)
         return;
      got.ctrl = ctrl_out;
      got.flit = flit_out;
      if (!prev_en[dest_fifo_out])
         fail_run($sformatf("flit at %0t went to %s while its enable was low",
                            $time, dest_fifo_out.name()));
      if (out_active)
      begin
         pop_expected(out_src, exp);   // same source until the tail
         check_entry("flit_out", got, exp);
         check_dest("dest_fifo_out", dest_fifo_out, out_dest);
         if (ctrl_out == flit_tail)
            out_active = 1'b0;
      end
      else
      begin
         if (ctrl_out != flit_head)
            fail_run($sformatf("body or tail flit at %0t outside a message", $time));
         qi  = int'(flit_out.head.misc[4:2]);
         rep = (qi % 2 == 1);
         if (qi == q_local_req || qi == q_local_rep || qi > q_inj_rep)
            fail_run($sformatf("head flit at %0t carries an unknown source tag", $time));
         pop_expected(qi, exp);
         check_entry("flit_out", got, exp);
         if (flit_out.head.dest_node == next_node)
            want = rep ? dest_local_rep : dest_local_req;
         else
            want = rep ? dest_pass_rep : dest_pass_req;
         check_dest("dest_fifo_out", dest_fifo_out, want);
         if (qi == q_inj_rep && want == dest_pass_rep
             && fifo_depth - int'(prev_used) < expected_len(flit_out.head.cmd))
            fail_run($sformatf("local reply at %0t entered the ring without room", $time));
         out_src    = qi;
         out_dest   = want;
         out_active = !(rep && expected_len(flit_out.head.cmd) == 1);
      end
   endtask

   // receive fifo fill is what the reference queues still hold
   task automatic check_receive_levels();
      check_level("en_pass_req", en_pass_req, wr_i[0] - rd_i[0] < fifo_depth);
      check_level("en_pass_rep", en_pass_rep, wr_i[1] - rd_i[1] < fifo_depth);
      check_level("en_local_req", en_local_req, wr_i[2] - rd_i[2] < fifo_depth);
      check_level("en_local_rep", en_local_rep, wr_i[3] - rd_i[3] < fifo_depth);
      check_count("used_slots_pass_rep", used_slots_pass_rep, cnt_w'(wr_i[1] - rd_i[1]));
   endtask

   task automatic tick();
      ni_entry_t exp;
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > timeout_cycles)
         fail_run("timeout, traffic did not drain within the cycle limit");
      check_ring_output();
      check_receive_levels();   // pass flits seen on the ring have left their fifo
      en_in_req_deq = 1'b0;
      en_in_rep_deq = 1'b0;
      if (deq_on && req_rdy && rand_below(2) == 0)
      begin
         pop_expected(q_local_req, exp);
         check_entry("deq_req_data", deq_req_data, exp);
         en_in_req_deq = 1'b1;
      end
      if (deq_on && rep_rdy && rand_below(2) == 0)
      begin
         pop_expected(q_local_rep, exp);
         check_entry("deq_rep_data", deq_rep_data, exp);
         en_in_rep_deq = 1'b1;
      end
      ctrl_in        = flit_idle;
      en_out_req_enq = 1'b0;
      en_out_rep_enq = 1'b0;
      // next node levels are mostly open
      en_pass_req_in         = credit_on && rand_below(4) != 0;
      en_pass_rep_in         = credit_on && rand_below(4) != 0;
      en_local_req_in        = credit_on && rand_below(4) != 0;
      en_local_rep_in        = credit_on && rand_below(4) != 0;
      used_slots_pass_rep_in = credit_on ? cnt_w'(rand_below(fifo_depth + 1)) : cnt_w'(fifo_depth);
      prev_en   = {en_local_rep_in, en_local_req_in, en_pass_rep_in, en_pass_req_in};
      prev_used = used_slots_pass_rep_in;
   endtask

   task automatic drive_traffic();
      ni_entry_t ent;
      if (g_left[0] == 0 && g_msgs[0] < msgs_per_gen)
         start_msg(0, rand_below(4));   // any receive fifo
      if (g_left[0] > 0 && link_enable(g_q[0]) && rand_below(4) != 0)
      begin
         send_flit(0, ent);
         ctrl_in      = ent.ctrl;
         flit_in      = ent.flit;
         dest_fifo_in = dest_fifo_t'(g_q[0]);
      end
      if (g_left[1] == 0 && g_msgs[1] < msgs_per_gen)
         start_msg(1, q_inj_req);
      if (g_left[1] > 0 && out_req_rdy && rand_below(2) == 0)
      begin
         send_flit(1, ent);
         enq_req_data   = ent;
         en_out_req_enq = 1'b1;
      end
      if (g_left[2] == 0 && g_msgs[2] < msgs_per_gen)
         start_msg(2, q_inj_rep);
      if (g_left[2] > 0 && out_rep_rdy && rand_below(2) == 0)
      begin
         send_flit(2, ent);
         enq_rep_data   = ent;
         en_out_rep_enq = 1'b1;
      end
   endtask

   initial
   begin
      seed = 32'hc3145da3;
      reset = 1'b1;
      ctrl_in = flit_idle;
      flit_in = '0;
      dest_fifo_in = dest_pass_req;
      enq_req_data = '0;
      enq_rep_data = '0;
      en_out_req_enq = 1'b0;
      en_out_rep_enq = 1'b0;
      en_in_req_deq = 1'b0;
      en_in_rep_deq = 1'b0;
      en_local_req_in = 1'b1;
      en_local_rep_in = 1'b1;
      en_pass_req_in = 1'b1;
      en_pass_rep_in = 1'b1;
      used_slots_pass_rep_in = '0;
      prev_en = 4'hf;
      prev_used = '0;
      deq_on = 1'b1;
      credit_on = 1'b1;
      out_active = 1'b0;
      out_src = 0;
      out_dest = dest_pass_req;
      cycles = 0;
      for (int i = 0; i < 6; i++)
      begin
         wr_i[i] = 0;
         rd_i[i] = 0;
      end
      for (int i = 0; i < 3; i++)
      begin
         g_q[i] = 0;
         g_len[i] = 0;
         g_left[i] = 0;
         g_msgs[i] = 0;
         g_head[i] = '0;
      end
      repeat (3) @(posedge clk);
      #2 reset = 1'b0;

      // state straight out of reset
      check_level("ctrl_out not idle", ctrl_out != flit_idle, 1'b0);
      check_level("req_rdy", req_rdy, 1'b0);
      check_level("rep_rdy", rep_rdy, 1'b0);
      check_level("en_pass_req", en_pass_req, 1'b1);
      check_level("en_pass_rep", en_pass_rep, 1'b1);
      check_level("en_local_req", en_local_req, 1'b1);
      check_level("en_local_rep", en_local_rep, 1'b1);
      check_level("out_req_rdy", out_req_rdy, 1'b1);
      check_level("out_rep_rdy", out_rep_rdy, 1'b1);

      while (!all_done())
      begin
         tick();
         drive_traffic();
      end

      // local request fifo fills up with no dequeues
      deq_on = 1'b0;
      for (int i = 0; i <= fifo_depth; i++)
      begin
         tick();
         check_level("en_local_req", en_local_req, i < fifo_depth);
         check_level("req_rdy", req_rdy, i > 0);
         if (i < fifo_depth)
         begin
            e.ctrl      = flit_body;
            e.flit.body = 16'(rand_below(65536));
            push(q_local_req, e);
            ctrl_in      = e.ctrl;
            flit_in      = e.flit;
            dest_fifo_in = dest_local_req;
         end
      end
      deq_on = 1'b1;

      // inject request fifo fills up while the next node gives no credit
      credit_on = 1'b0;
      for (int i = 0; i <= fifo_depth; i++)
      begin
         tick();
         check_level("out_req_rdy", out_req_rdy, i < fifo_depth);
         if (i < fifo_depth)
         begin
            if (g_left[1] == 0)
               start_msg(1, q_inj_req);
            send_flit(1, e);
            enq_req_data   = e;
            en_out_req_enq = 1'b1;
         end
      end
      credit_on = 1'b1;

      while (!all_done())
      begin
         tick();
         drive_traffic();   // finishes the partial inject message
      end
      tick();
      check_level("ctrl_out not idle", ctrl_out != flit_idle, 1'b0);
      check_level("req_rdy", req_rdy, 1'b0);
      check_level("rep_rdy", rep_rdy, 1'b0);

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
source/noc_ni_pkg.sv
source/flit_fifo.sv
source/ring_receive.sv
source/ring_transmit_arbiter.sv
source/network_interface.sv
sim/network_interface_tb.sv

//--- Bender.yml
package:
  name: noc_ring_ni

sources:
  # package first, then leaf modules up to the top level
  - source/noc_ni_pkg.sv
  - source/flit_fifo.sv
  - source/ring_receive.sv
  - source/ring_transmit_arbiter.sv
  - source/network_interface.sv
  - target: test
    files:
      - sim/network_interface_tb.sv
